// ==== build.f ====
+incdir+test
design/debug_pkg.sv
design/cycle_counter.sv
design/pipeline_snapshot.sv
design/debug_sequencer.sv
design/word_serializer.sv
design/debug_unit_top.sv
test/debug_unit_tb.sv

// ==== design/cycle_counter.sv ====
`timescale 1ns/1ns

module cycle_counter #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                    i_clock,
    input  logic                    i_soft_reset,
    input  logic                    i_run,
    input  logic                    i_halt_detected_ex_mem,
    input  logic                    i_clear_pulse,
    output logic [ADDR_WIDTH-1:0]   o_cycles
);

    logic halted;  // Sticky, set once a halt reaches EX/MEM.

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset || i_clear_pulse) begin
            o_cycles <= '0;
            halted   <= 1'b0;
        end
        else begin
            if (i_halt_detected_ex_mem) begin
                halted <= 1'b1;
            end
            // Count wraps at full width.
            if (i_run && !halted) begin
                o_cycles <= o_cycles + 1'b1;
            end
        end
    end

endmodule

// ==== design/debug_pkg.sv ====
package debug_pkg;

    // Datapath widths of the MIPS pipeline.
    localparam int INSTR_WIDTH    = 32;  // One instruction or data word.
    localparam int REG_ADDR_WIDTH = 5;
    localparam int ALU_OP_WIDTH   = 2;
    localparam int ALU_CTRL_WIDTH = 4;
    localparam int BYTE_SEL_WIDTH = 2;   // Data memory byte select.

    // Snapshot commands and read codes.
    typedef enum logic [3:0] {
        SEL_HOLD      = 4'd0,
        SEL_CAPTURE   = 4'd1,
        SEL_PC        = 4'd2,
        SEL_CYCLES    = 4'd3,
        SEL_ADDER_PC  = 4'd4,
        SEL_INSTR     = 4'd5,
        SEL_BRANCH    = 4'd6,
        SEL_DATA_A    = 4'd7,
        SEL_DATA_B    = 4'd8,
        SEL_IMM       = 4'd9,
        SEL_REGS      = 4'd10,
        SEL_ID_CTRL   = 4'd11,
        SEL_ALU       = 4'd12,
        SEL_MEM_WDATA = 4'd13,
        SEL_EX_CTRL   = 4'd14,
        SEL_CLEAR     = 4'd15
    } select_code_t;

    localparam select_code_t FIRST_READ_CODE = SEL_PC;       // First word of a dump.
    localparam select_code_t LAST_READ_CODE  = SEL_EX_CTRL;  // Last word of a dump.

endpackage

// ==== design/debug_sequencer.sv ====
`timescale 1ns/1ns

module debug_sequencer (
    input  logic                     i_clock,
    input  logic                     i_soft_reset,
    input  logic                     i_dump_start,
    input  logic                     i_clear,
    input  logic                     i_ser_busy,
    output debug_pkg::select_code_t  o_select,
    output logic                     o_word_load,
    output logic                     o_clear_pulse,
    output logic                     o_dump_done,
    output logic                     o_busy
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CAPTURE,
        S_SELECT,
        S_LOAD,
        S_WAIT
    } state_t;

    state_t                  state;
    debug_pkg::select_code_t code;  // Read code being walked.

    ////////////////////////////////////////////////////////////////////////////
    // Dump FSM. Each read code takes six cycles: select, load, then four bytes.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            state         <= S_IDLE;
            code          <= debug_pkg::FIRST_READ_CODE;
            o_clear_pulse <= 1'b0;
            o_dump_done   <= 1'b0;
        end
        else begin
            o_clear_pulse <= 1'b0;
            o_dump_done   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_dump_start) begin
                        state <= S_CAPTURE;
                    end
                    else if (i_clear) begin
                        o_clear_pulse <= 1'b1;
                    end
                end
                S_CAPTURE: begin
                    code  <= debug_pkg::FIRST_READ_CODE;
                    state <= S_SELECT;
                end
                S_SELECT: state <= S_LOAD;   // Snapshot word ready next cycle.
                S_LOAD:   state <= S_WAIT;
                S_WAIT: begin
                    // Busy drops while the last byte is out.
                    if (!i_ser_busy) begin
                        if (code == debug_pkg::LAST_READ_CODE) begin
                            o_dump_done <= 1'b1;
                            state       <= S_IDLE;
                        end
                        else begin
                            code  <= debug_pkg::select_code_t'(code + 4'd1);
                            state <= S_SELECT;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        case (state)
            S_CAPTURE: o_select = debug_pkg::SEL_CAPTURE;
            S_SELECT:  o_select = code;
            default:   o_select = o_clear_pulse ? debug_pkg::SEL_CLEAR : debug_pkg::SEL_HOLD;
        endcase
    end

    assign o_word_load = (state == S_LOAD);
    assign o_busy      = (state != S_IDLE);  // Starts and clears are ignored meanwhile.

endmodule

// ==== design/debug_unit_top.sv ====
`timescale 1ns/1ns

module debug_unit_top #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                                  i_clock,
    input  logic                                  i_soft_reset,
    input  logic                                  i_run,
    input  logic                                  i_halt_detected_ex_mem,
    input  logic                                  i_dump_start,
    input  logic                                  i_clear,
    // Pipeline probes.
    input  logic [ADDR_WIDTH-1:0]                 i_pc,
    input  logic [ADDR_WIDTH-1:0]                 i_adder_pc,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_instruction,
    input  logic [ADDR_WIDTH-1:0]                 i_branch_dir,
    input  logic                                  i_branch_taken,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_data_a,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_data_b,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_imm_ext,
    input  logic [debug_pkg::REG_ADDR_WIDTH-1:0]  i_reg_rs,
    input  logic [debug_pkg::REG_ADDR_WIDTH-1:0]  i_reg_rt,
    input  logic [debug_pkg::REG_ADDR_WIDTH-1:0]  i_reg_rd,
    input  logic                                  i_halt_id_ex,
    input  logic                                  i_reg_dst,
    input  logic                                  i_reg_write_id_ex,
    input  logic                                  i_alu_src,
    input  logic [debug_pkg::ALU_OP_WIDTH-1:0]    i_alu_op,
    input  logic                                  i_mem_read_id_ex,
    input  logic                                  i_mem_write_id_ex,
    input  logic                                  i_mem_to_reg_id_ex,
    input  logic [debug_pkg::ALU_CTRL_WIDTH-1:0]  i_alu_ctrl,
    input  logic [debug_pkg::BYTE_SEL_WIDTH-1:0]  i_byte_sel_id_ex,
    input  logic                                  i_reg_write_ex_mem,
    input  logic                                  i_mem_read_ex_mem,
    input  logic                                  i_mem_write_ex_mem,
    input  logic                                  i_mem_to_reg_ex_mem,
    input  logic [debug_pkg::BYTE_SEL_WIDTH-1:0]  i_byte_sel_ex_mem,
    input  logic                                  i_halt_ex_mem,
    input  logic [debug_pkg::REG_ADDR_WIDTH-1:0]  i_dest_reg_ex_mem,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_alu_result,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_mem_wdata,
    // Byte stream out.
    output logic [7:0]                            o_byte,
    output logic                                  o_byte_valid,
    output logic                                  o_dump_done,
    output logic                                  o_busy
);

    logic [ADDR_WIDTH-1:0]             cycles;
    debug_pkg::select_code_t           sel_code;
    logic [debug_pkg::INSTR_WIDTH-1:0] snap_data;
    logic                              word_load;
    logic                              clear_pulse;
    logic                              ser_busy;

    cycle_counter #(.ADDR_WIDTH(ADDR_WIDTH)) u_cycle_counter (
        .i_clock                (i_clock),
        .i_soft_reset           (i_soft_reset),
        .i_run                  (i_run),
        .i_halt_detected_ex_mem (i_halt_detected_ex_mem),
        .i_clear_pulse          (clear_pulse),
        .o_cycles               (cycles)
    );

    // Probe ports share their names with the snapshot's.
    pipeline_snapshot #(.ADDR_WIDTH(ADDR_WIDTH)) u_snapshot (
        .*,
        .i_select (sel_code),
        .i_cycles (cycles),
        .o_data   (snap_data)
    );

    debug_sequencer u_sequencer (
        .i_clock       (i_clock),
        .i_soft_reset  (i_soft_reset),
        .i_dump_start  (i_dump_start),
        .i_clear       (i_clear),
        .i_ser_busy    (ser_busy),
        .o_select      (sel_code),
        .o_word_load   (word_load),
        .o_clear_pulse (clear_pulse),
        .o_dump_done   (o_dump_done),
        .o_busy        (o_busy)
    );

    word_serializer u_serializer (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_word_load  (word_load),
        .i_word       (snap_data),
        .o_byte       (o_byte),
        .o_byte_valid (o_byte_valid),
        .o_busy       (ser_busy)
    );

endmodule

// ==== design/pipeline_snapshot.sv ====
`timescale 1ns/1ns

module pipeline_snapshot #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                                  i_clock,
    input  logic                                  i_soft_reset,
    input  debug_pkg::select_code_t               i_select,
    input  logic [ADDR_WIDTH-1:0]                 i_cycles,
    // Instruction fetch.
    input  logic [ADDR_WIDTH-1:0]                 i_pc,
    input  logic [ADDR_WIDTH-1:0]                 i_adder_pc,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_instruction,
    // Instruction decode.
    input  logic [ADDR_WIDTH-1:0]                 i_branch_dir,
    input  logic                                  i_branch_taken,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_data_a,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_data_b,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_imm_ext,
    input  logic [debug_pkg::REG_ADDR_WIDTH-1:0]  i_reg_rs,
    input  logic [debug_pkg::REG_ADDR_WIDTH-1:0]  i_reg_rt,
    input  logic [debug_pkg::REG_ADDR_WIDTH-1:0]  i_reg_rd,
    input  logic                                  i_halt_id_ex,
    input  logic                                  i_reg_dst,
    input  logic                                  i_reg_write_id_ex,
    input  logic                                  i_alu_src,
    input  logic [debug_pkg::ALU_OP_WIDTH-1:0]    i_alu_op,
    input  logic                                  i_mem_read_id_ex,
    input  logic                                  i_mem_write_id_ex,
    input  logic                                  i_mem_to_reg_id_ex,
    input  logic [debug_pkg::ALU_CTRL_WIDTH-1:0]  i_alu_ctrl,
    input  logic [debug_pkg::BYTE_SEL_WIDTH-1:0]  i_byte_sel_id_ex,
    // Execute.
    input  logic                                  i_reg_write_ex_mem,
    input  logic                                  i_mem_read_ex_mem,
    input  logic                                  i_mem_write_ex_mem,
    input  logic                                  i_mem_to_reg_ex_mem,
    input  logic [debug_pkg::BYTE_SEL_WIDTH-1:0]  i_byte_sel_ex_mem,
    input  logic                                  i_halt_ex_mem,
    input  logic [debug_pkg::REG_ADDR_WIDTH-1:0]  i_dest_reg_ex_mem,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_alu_result,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]     i_mem_wdata,
    output logic [debug_pkg::INSTR_WIDTH-1:0]     o_data
);

    localparam int REGS_WIDTH    = 3 * debug_pkg::REG_ADDR_WIDTH;
    localparam int ID_CTRL_WIDTH = debug_pkg::BYTE_SEL_WIDTH + 7 + debug_pkg::ALU_OP_WIDTH
                                   + debug_pkg::ALU_CTRL_WIDTH;
    localparam int EX_CTRL_WIDTH = 5 + debug_pkg::BYTE_SEL_WIDTH + debug_pkg::REG_ADDR_WIDTH;

    typedef logic [debug_pkg::INSTR_WIDTH-1:0] word_t;

    // One frozen register per read code, already packed in readout order.
    logic [ADDR_WIDTH-1:0]    snap_pc;
    logic [ADDR_WIDTH-1:0]    snap_cycles;
    logic [ADDR_WIDTH-1:0]    snap_adder_pc;
    word_t                    snap_instr;
    logic [ADDR_WIDTH:0]      snap_branch;    // Taken flag above the address.
    word_t                    snap_data_a;
    word_t                    snap_data_b;
    word_t                    snap_imm;
    logic [REGS_WIDTH-1:0]    snap_regs;      // rs, rt, rd.
    logic [ID_CTRL_WIDTH-1:0] snap_id_ctrl;
    word_t                    snap_alu;
    word_t                    snap_mem_wdata;
    logic [EX_CTRL_WIDTH-1:0] snap_ex_ctrl;

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset || i_select == debug_pkg::SEL_CLEAR) begin
            snap_pc        <= '0;
            snap_cycles    <= '0;
            snap_adder_pc  <= ADDR_WIDTH'(4);  // Next PC after address zero.
            snap_instr     <= '0;
            snap_branch    <= '0;
            snap_data_a    <= '0;
            snap_data_b    <= '0;
            snap_imm       <= '0;
            snap_regs      <= '0;
            snap_id_ctrl   <= '0;
            snap_alu       <= '0;
            snap_mem_wdata <= '0;
            snap_ex_ctrl   <= '0;
            o_data         <= '0;
        end
        else if (i_select == debug_pkg::SEL_CAPTURE) begin
            snap_pc        <= i_pc;
            snap_cycles    <= i_cycles;
            snap_adder_pc  <= i_adder_pc;
            snap_instr     <= i_instruction;
            snap_branch    <= {i_branch_taken, i_branch_dir};
            snap_data_a    <= i_data_a;
            snap_data_b    <= i_data_b;
            snap_imm       <= i_imm_ext;
            snap_regs      <= {i_reg_rs, i_reg_rt, i_reg_rd};
            snap_id_ctrl   <= {i_byte_sel_id_ex, i_halt_id_ex, i_reg_dst, i_reg_write_id_ex,
                               i_alu_src, i_mem_read_id_ex, i_mem_write_id_ex,
                               i_mem_to_reg_id_ex, i_alu_op, i_alu_ctrl};
            snap_alu       <= i_alu_result;
            snap_mem_wdata <= i_mem_wdata;
            snap_ex_ctrl   <= {i_reg_write_ex_mem, i_mem_read_ex_mem, i_mem_write_ex_mem,
                               i_mem_to_reg_ex_mem, i_byte_sel_ex_mem, i_halt_ex_mem,
                               i_dest_reg_ex_mem};
            o_data         <= '0;
        end
        else begin
            // Readout, zero-extended to a full word.
            case (i_select)
                debug_pkg::SEL_PC:        o_data <= word_t'(snap_pc);
                debug_pkg::SEL_CYCLES:    o_data <= word_t'(snap_cycles);
                debug_pkg::SEL_ADDER_PC:  o_data <= word_t'(snap_adder_pc);
                debug_pkg::SEL_INSTR:     o_data <= snap_instr;
                debug_pkg::SEL_BRANCH:    o_data <= word_t'(snap_branch);
                debug_pkg::SEL_DATA_A:    o_data <= snap_data_a;
                debug_pkg::SEL_DATA_B:    o_data <= snap_data_b;
                debug_pkg::SEL_IMM:       o_data <= snap_imm;
                debug_pkg::SEL_REGS:      o_data <= word_t'(snap_regs);
                debug_pkg::SEL_ID_CTRL:   o_data <= word_t'(snap_id_ctrl);
                debug_pkg::SEL_ALU:       o_data <= snap_alu;
                debug_pkg::SEL_MEM_WDATA: o_data <= snap_mem_wdata;
                debug_pkg::SEL_EX_CTRL:   o_data <= word_t'(snap_ex_ctrl);
                default:                  o_data <= o_data;  // Hold.
            endcase
        end
    end

endmodule

// ==== design/word_serializer.sv ====
`timescale 1ns/1ns

module word_serializer (
    input  logic                               i_clock,
    input  logic                               i_soft_reset,
    input  logic                               i_word_load,
    input  logic [debug_pkg::INSTR_WIDTH-1:0]  i_word,
    output logic [7:0]                         o_byte,
    output logic                               o_byte_valid,
    output logic                               o_busy
);

    logic [debug_pkg::INSTR_WIDTH-1:0] shift;
    logic [1:0]                        bytes_left;  // Bytes still queued behind o_byte.

    // Byte 0 goes out on the load edge itself.
    always_ff @(posedge i_clock) begin
        if (i_word_load) begin
            o_byte <= i_word[7:0];
            shift  <= i_word >> 8;
        end
        else begin
            o_byte <= shift[7:0];
            shift  <= shift >> 8;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            bytes_left   <= 2'd0;
            o_byte_valid <= 1'b0;
        end
        else if (i_word_load) begin
            bytes_left   <= 2'd3;
            o_byte_valid <= 1'b1;
        end
        else if (bytes_left != 2'd0) begin
            bytes_left   <= bytes_left - 2'd1;
            o_byte_valid <= 1'b1;
        end
        else begin
            o_byte_valid <= 1'b0;
        end
    end

    // Low again during the last byte.
    assign o_busy = (bytes_left != 2'd0);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module debug_unit_tb -f build.f

# A fatal stop exits nonzero, so keep the output and judge it below.
output="$(./obj_dir/Vdebug_unit_tb 2>&1 || true)"
echo "$output"

if grep -q "Simulation finished: PASS" <<< "$output"; then
    exit 0
fi
echo "run_sim.sh: simulation failed" >&2
exit 1

// ==== test/snapshot_model.svh ====
`ifndef SNAPSHOT_MODEL_SVH
`define SNAPSHOT_MODEL_SVH

    typedef logic [debug_pkg::INSTR_WIDTH-1:0] word_t;

    // Cycle counter as the DUT should hold it.
    logic [ADDR_WIDTH-1:0] model_cycles;
    logic                  model_halted;  // Sticky halt seen.
    word_t                 expected_words[$];

    // One readout word, built bit by bit from the probe values.
    function automatic word_t pack_field(input debug_pkg::select_code_t code);
        word_t w;
        w = '0;
        case (code)
            debug_pkg::SEL_PC:        w[ADDR_WIDTH-1:0] = i_pc;
            debug_pkg::SEL_CYCLES:    w[ADDR_WIDTH-1:0] = model_cycles;
            debug_pkg::SEL_ADDER_PC:  w[ADDR_WIDTH-1:0] = i_adder_pc;
            debug_pkg::SEL_INSTR:     w = i_instruction;
            debug_pkg::SEL_BRANCH: begin
                w[ADDR_WIDTH-1:0] = i_branch_dir;
                w[ADDR_WIDTH]     = i_branch_taken;
            end
            debug_pkg::SEL_DATA_A:    w = i_data_a;
            debug_pkg::SEL_DATA_B:    w = i_data_b;
            debug_pkg::SEL_IMM:       w = i_imm_ext;
            debug_pkg::SEL_REGS: begin
                w[14:10] = i_reg_rs;
                w[9:5]   = i_reg_rt;
                w[4:0]   = i_reg_rd;
            end
            debug_pkg::SEL_ID_CTRL: begin
                w[3:0]   = i_alu_ctrl;
                w[5:4]   = i_alu_op;
                w[6]     = i_mem_to_reg_id_ex;
                w[7]     = i_mem_write_id_ex;
                w[8]     = i_mem_read_id_ex;
                w[9]     = i_alu_src;
                w[10]    = i_reg_write_id_ex;
                w[11]    = i_reg_dst;
                w[12]    = i_halt_id_ex;
                w[14:13] = i_byte_sel_id_ex;  // Top of the control word.
            end
            debug_pkg::SEL_ALU:       w = i_alu_result;
            debug_pkg::SEL_MEM_WDATA: w = i_mem_wdata;
            debug_pkg::SEL_EX_CTRL: begin
                w[4:0]   = i_dest_reg_ex_mem;
                w[5]     = i_halt_ex_mem;
                w[7:6]   = i_byte_sel_ex_mem;
                w[8]     = i_mem_to_reg_ex_mem;
                w[9]     = i_mem_write_ex_mem;
                w[10]    = i_mem_read_ex_mem;
                w[11]    = i_reg_write_ex_mem;
            end
            default:                  w = '0;
        endcase
        return w;
    endfunction

    // Expected dump, taken from the probes as they stand at the capture edge.
    function automatic void load_expected();
        expected_words.delete();
        for (int code = int'(debug_pkg::FIRST_READ_CODE);
             code <= int'(debug_pkg::LAST_READ_CODE); code++) begin
            expected_words.push_back(pack_field(debug_pkg::select_code_t'(code)));
        end
    endfunction

`endif

// ==== test/debug_unit_tb.sv ====
`timescale 1ns/1ns

module debug_unit_tb;

    localparam int ADDR_WIDTH     = 11;
    localparam int DUMP_WORDS     = 13;
    localparam int DUMP_TIMEOUT   = 200;  // Cycles. A dump takes 79.
    localparam int QUIET_CYCLES   = 20;

    logic i_clock;
    logic i_soft_reset;
    logic i_run, i_halt_detected_ex_mem, i_dump_start, i_clear;
    logic [ADDR_WIDTH-1:0] i_pc, i_adder_pc, i_branch_dir;
    logic [debug_pkg::INSTR_WIDTH-1:0] i_instruction, i_data_a, i_data_b, i_imm_ext;
    logic [debug_pkg::INSTR_WIDTH-1:0] i_alu_result, i_mem_wdata;
    logic [debug_pkg::REG_ADDR_WIDTH-1:0] i_reg_rs, i_reg_rt, i_reg_rd, i_dest_reg_ex_mem;
    logic i_branch_taken, i_halt_id_ex, i_reg_dst, i_reg_write_id_ex, i_alu_src;
    logic i_mem_read_id_ex, i_mem_write_id_ex, i_mem_to_reg_id_ex;
    logic i_reg_write_ex_mem, i_mem_read_ex_mem, i_mem_write_ex_mem, i_mem_to_reg_ex_mem;
    logic i_halt_ex_mem;
    logic [debug_pkg::ALU_OP_WIDTH-1:0]   i_alu_op;
    logic [debug_pkg::ALU_CTRL_WIDTH-1:0] i_alu_ctrl;
    logic [debug_pkg::BYTE_SEL_WIDTH-1:0] i_byte_sel_id_ex, i_byte_sel_ex_mem;
    logic [7:0] o_byte;
    logic o_byte_valid, o_dump_done, o_busy;
    logic [31:0] rng_state;

`include "snapshot_model.svh"

    debug_unit_top #(.ADDR_WIDTH(ADDR_WIDTH)) i_dut (.*);

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks.
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h",
                                        name, got, expected));
        end
    endtask

    // 32-bit xorshift.
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic randomize_probes();
        logic [31:0] r;
        r = next_random();
        i_pc               = r[ADDR_WIDTH-1:0];
        i_adder_pc         = r[31-:ADDR_WIDTH];
        i_branch_taken     = r[11];
        i_halt_id_ex       = r[12];
        i_reg_dst          = r[13];
        i_reg_write_id_ex  = r[14];
        i_alu_src          = r[15];
        i_mem_read_id_ex   = r[16];
        i_mem_write_id_ex  = r[17];
        i_mem_to_reg_id_ex = r[18];
        i_byte_sel_id_ex   = r[20:19];
        r = next_random();
        i_branch_dir = r[ADDR_WIDTH-1:0];
        i_alu_op     = r[12:11];
        i_alu_ctrl   = r[16:13];
        i_reg_rs     = r[21:17];
        i_reg_rt     = r[26:22];
        i_reg_rd     = r[31:27];
        r = next_random();
        i_dest_reg_ex_mem   = r[4:0];
        i_byte_sel_ex_mem   = r[6:5];
        i_reg_write_ex_mem  = r[7];
        i_mem_read_ex_mem   = r[8];
        i_mem_write_ex_mem  = r[9];
        i_mem_to_reg_ex_mem = r[10];
        i_halt_ex_mem       = r[11];
        i_instruction = next_random();
        i_data_a      = next_random();
        i_data_b      = next_random();
        i_imm_ext     = next_random();
        i_alu_result  = next_random();
        i_mem_wdata   = next_random();
    endtask

    // Matches the snapshot after a clear.
    task automatic zero_probes();
        {i_pc, i_branch_dir, i_branch_taken, i_instruction, i_data_a, i_data_b, i_imm_ext,
         i_reg_rs, i_reg_rt, i_reg_rd, i_halt_id_ex, i_reg_dst, i_reg_write_id_ex,
         i_alu_src, i_alu_op, i_mem_read_id_ex, i_mem_write_id_ex, i_mem_to_reg_id_ex,
         i_alu_ctrl, i_byte_sel_id_ex, i_reg_write_ex_mem, i_mem_read_ex_mem,
         i_mem_write_ex_mem, i_mem_to_reg_ex_mem, i_byte_sel_ex_mem, i_halt_ex_mem,
         i_dest_reg_ex_mem, i_alu_result, i_mem_wdata} = '0;
        i_adder_pc = ADDR_WIDTH'(4);
    endtask

    task automatic run_cycles(input int count);
        @(negedge i_clock);
        i_run = 1'b1;
        repeat (count) @(negedge i_clock);
        i_run = 1'b0;
        if (!model_halted) begin
            model_cycles = model_cycles + ADDR_WIDTH'(count);
        end
    endtask

    task automatic pulse_halt();
        @(negedge i_clock);
        i_halt_detected_ex_mem = 1'b1;
        @(negedge i_clock);
        i_halt_detected_ex_mem = 1'b0;
        model_halted = 1'b1;
    endtask

    task automatic pulse_clear();
        @(negedge i_clock);
        i_clear = 1'b1;
        @(negedge i_clock);
        i_clear = 1'b0;
        repeat (3) @(negedge i_clock);  // Counter clears two edges later.
        model_cycles = '0;
        model_halted = 1'b0;
    endtask

    task automatic check_quiet(input int count, input string when);
        repeat (count) begin
            @(negedge i_clock);
            if (o_byte_valid !== 1'b0 || o_dump_done !== 1'b0 || o_busy !== 1'b0) begin
                stop_with_failure($sformatf("Outputs not idle %s", when));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One dump, checked byte by byte.
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_dump(input bit scramble, input bit retrigger);
        logic [7:0] got_bytes[$];
        int         cycles;
        int         done_count;
        int         idx;
        load_expected();
        @(negedge i_clock);
        i_dump_start = 1'b1;
        @(negedge i_clock);
        i_dump_start = 1'b0;
        @(negedge i_clock);  // Capture edge has passed.
        cycles     = 0;
        done_count = 0;
        while (done_count == 0 && cycles < DUMP_TIMEOUT) begin
            if (scramble) begin
                randomize_probes();
            end
            i_dump_start = retrigger && (cycles == 20);
            @(negedge i_clock);
            cycles++;
            if (o_byte_valid) begin
                idx = got_bytes.size();
                if (idx >= 4 * DUMP_WORDS) begin
                    stop_with_failure("More than 52 bytes came out of one dump");
                end
                compare_byte($sformatf("o_byte[%0d]", idx), o_byte,
                             8'(expected_words[idx / 4] >> (8 * (idx % 4))));
                got_bytes.push_back(o_byte);
            end
            if (!o_dump_done && o_busy !== 1'b1) begin
                stop_with_failure("o_busy was low in the middle of a dump");
            end
            if (o_dump_done) begin
                done_count++;
            end
        end
        i_dump_start = 1'b0;
        if (done_count == 0) begin
            stop_with_failure("Timed out waiting for o_dump_done");
        end
        if (got_bytes.size() != 4 * DUMP_WORDS) begin
            stop_with_failure($sformatf("Dump gave %0d bytes instead of 52", got_bytes.size()));
        end
        check_quiet(QUIET_CYCLES, "after o_dump_done");  // No second dump or done pulse.
    endtask

    initial begin
        rng_state              = 32'd25;
        i_soft_reset           = 1'b0;
        i_run                  = 1'b0;
        i_halt_detected_ex_mem = 1'b0;
        i_dump_start           = 1'b0;
        i_clear                = 1'b0;
        zero_probes();
        model_cycles = '0;
        model_halted = 1'b0;
        repeat (4) @(negedge i_clock);
        i_soft_reset = 1'b1;

        check_quiet(8, "after reset");

        randomize_probes();
        run_dump(1'b0, 1'b0);

        randomize_probes();
        run_dump(1'b1, 1'b0);  // Probes move during the readout.

        randomize_probes();
        run_cycles(37);
        run_dump(1'b0, 1'b0);
        run_cycles(5);
        pulse_halt();
        run_cycles(25);        // Frozen by the halt.
        run_dump(1'b0, 1'b0);

        pulse_clear();
        zero_probes();
        run_dump(1'b0, 1'b0);
        run_cycles(6);         // Halt flag went with the clear.
        run_dump(1'b0, 1'b0);

        randomize_probes();
        run_dump(1'b0, 1'b1);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
